// File: verilog/lsu_cfg_pkg.sv
package lsu_cfg_pkg;

  // ======================================================================
  // address side
  // ======================================================================
  // physical address width of the walker
  localparam int PA_W = 40;
  typedef logic [PA_W-1:0] pa_t;

  // ======================================================================
  // data side
  // ======================================================================
  // one doubleword per read and per cache line
  localparam int DW_W = 64;
  typedef logic [DW_W-1:0] dword_t;

  // byte lanes in a doubleword
  localparam int DW_BYTES = DW_W / 8;
  typedef logic [DW_BYTES-1:0] byte_mask_t;

  // byte offset inside a line
  localparam int DW_OFFSET_W = 3;

  // stored tag, full address width
  // offset and index bits kept at zero
  typedef logic [PA_W-1:0] dc_tag_t;

endpackage

// File: verilog/lsu_ctrl_pkg.sv
package lsu_ctrl_pkg;

  // privilege modes, riscv encoding
  typedef logic [1:0] priv_t;
  localparam priv_t PRIV_U = 2'b00;
  localparam priv_t PRIV_S = 2'b01;
  localparam priv_t PRIV_M = 2'b11;

  // walker request fsm
  typedef enum logic [1:0] {
    PTW_IDLE       = 2'b00,
    PTW_REQ_DCACHE = 2'b01,
    PTW_WAIT_DATA  = 2'b10
  } ptw_state_t;

  // dcache stage fsm
  typedef enum logic [2:0] {
    DC_IDLE     = 3'd0,
    DC_LOOKUP   = 3'd1,
    DC_BUS_ADDR = 3'd2,
    DC_BUS_DATA = 3'd3,
    DC_RESPOND  = 3'd4
  } dc_state_t;

  // axi read response codes
  typedef logic [1:0] axi_resp_t;
  localparam axi_resp_t AXI_OKAY   = 2'b00;
  localparam axi_resp_t AXI_SLVERR = 2'b10;

endpackage

// File: verilog/dc_req_if.sv
`timescale 1ns/100ps

// ========================================================================
// walker to dcache stage request
// ========================================================================
interface dc_req_if;
  // request, valid only in the grant cycle
  logic                    req;
  lsu_cfg_pkg::pa_t        addr;
  lsu_cfg_pkg::byte_mask_t bytes_vld;
  lsu_ctrl_pkg::priv_t     priv_mode;
  // response back to the walker
  logic                    resp_vld;
  logic                    resp_err;
  lsu_cfg_pkg::dword_t     resp_data;

  modport mcic (
    output req, addr, bytes_vld, priv_mode,
    input  resp_vld, resp_err, resp_data
  );

  modport dc (
    input  req, addr, bytes_vld, priv_mode,
    output resp_vld, resp_err, resp_data
  );
endinterface

// ========================================================================
// dcache array port
// ========================================================================
interface array_if #(
  parameter int DC_SETS = 64
);
  localparam int IDX_W = $clog2(DC_SETS);

  // read side, from the arbiter
  logic                    rd_en;
  logic [IDX_W-1:0]        rd_idx;
  // refill side, from the arbiter
  logic                    wr_en;
  logic [IDX_W-1:0]        wr_idx;
  lsu_cfg_pkg::dc_tag_t    wr_tag;
  lsu_cfg_pkg::dword_t     wr_data;
  // registered read result
  logic                    rd_vld;
  lsu_cfg_pkg::dc_tag_t    rd_tag;
  lsu_cfg_pkg::dword_t     rd_data;

  modport arb (
    output rd_en, rd_idx, wr_en, wr_idx, wr_tag, wr_data
  );

  modport array (
    input  rd_en, rd_idx, wr_en, wr_idx, wr_tag, wr_data,
    output rd_vld, rd_tag, rd_data
  );

  // dcache stage only sees the read result
  modport dc (
    input  rd_vld, rd_tag, rd_data
  );
endinterface

// File: verilog/lsu_mcic.sv
`timescale 1ns/100ps

module lsu_mcic (
  input  logic                 ptw_clk,
  input  logic                 cpurst_b,
  input  logic                 mmu_req,
  input  lsu_cfg_pkg::pa_t     mmu_addr,
  input  logic                 mmu_size,
  input  logic                 mprv,
  input  lsu_ctrl_pkg::priv_t  mpp,
  input  lsu_ctrl_pkg::priv_t  priv_mode,
  input  logic                 icc_idle,
  input  logic                 dc_busy,
  input  logic                 arb_grant,
  output logic                 arb_req,
  output lsu_cfg_pkg::pa_t     rd_addr,
  output logic                 mmu_data_vld,
  output logic                 mmu_bus_err,
  output lsu_cfg_pkg::dword_t  mmu_data,
  dc_req_if.mcic               dc_req
);

  lsu_ctrl_pkg::ptw_state_t ptw_cur_state;
  lsu_ctrl_pkg::ptw_state_t ptw_next_state;
  logic                     ptw_frz;
  logic                     ptw_grant;
  lsu_cfg_pkg::byte_mask_t  mmu_bytes_vld;

  // ======================================================================
  // walker fsm
  // ======================================================================
  always_ff @(posedge ptw_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      ptw_cur_state <= lsu_ctrl_pkg::PTW_IDLE;
    else
      ptw_cur_state <= ptw_next_state;
  end

  always_comb begin
    ptw_next_state = ptw_cur_state;
    case (ptw_cur_state)
      lsu_ctrl_pkg::PTW_IDLE: begin
        // grant may come in the very cycle the request rises
        if (ptw_grant)
          ptw_next_state = lsu_ctrl_pkg::PTW_WAIT_DATA;
        else if (mmu_req)
          ptw_next_state = lsu_ctrl_pkg::PTW_REQ_DCACHE;
      end
      lsu_ctrl_pkg::PTW_REQ_DCACHE: begin
        if (ptw_grant)
          ptw_next_state = lsu_ctrl_pkg::PTW_WAIT_DATA;
      end
      lsu_ctrl_pkg::PTW_WAIT_DATA: begin
        if (dc_req.resp_vld || dc_req.resp_err)
          ptw_next_state = lsu_ctrl_pkg::PTW_IDLE;
      end
      default: ptw_next_state = lsu_ctrl_pkg::PTW_IDLE;
    endcase
  end

  // no new request while one is outstanding
  assign ptw_frz   = (ptw_cur_state == lsu_ctrl_pkg::PTW_WAIT_DATA);
  assign arb_req   = mmu_req && !ptw_frz && !dc_busy && icc_idle;
  // arbiter already excludes refill cycles
  assign ptw_grant = arb_req && arb_grant;
  assign rd_addr   = mmu_addr;

  // ======================================================================
  // byte lanes
  // ======================================================================
  always_comb begin
    case ({mmu_size, mmu_addr[2]})
      2'b00:   mmu_bytes_vld = 8'h0f;
      2'b01:   mmu_bytes_vld = 8'hf0;
      // 64-bit must be doubleword aligned
      2'b10:   mmu_bytes_vld = (mmu_addr[1:0] == 2'b00) ? 8'hff : 8'h00;
      default: mmu_bytes_vld = 8'h00;
    endcase
  end

  // ======================================================================
  // to dcache stage and back to mmu
  // ======================================================================
  assign dc_req.req       = ptw_grant;
  assign dc_req.addr      = mmu_addr;
  assign dc_req.bytes_vld = mmu_bytes_vld;
  // mprv borrows the previous mode
  assign dc_req.priv_mode = mprv ? mpp : priv_mode;

  assign mmu_data_vld = dc_req.resp_vld;
  assign mmu_bus_err  = dc_req.resp_err;
  assign mmu_data     = dc_req.resp_data;

endmodule

// File: verilog/lsu_dcache_arb.sv
`timescale 1ns/100ps

module lsu_dcache_arb #(
  parameter int DC_SETS = 64
) (
  input  logic                 ptw_clk,
  input  logic                 cpurst_b,
  input  logic                 arb_req,
  input  lsu_cfg_pkg::pa_t     rd_addr,
  input  logic                 refill_vld,
  input  lsu_cfg_pkg::pa_t     refill_addr,
  input  lsu_cfg_pkg::dword_t  refill_data,
  output logic                 arb_grant,
  output lsu_cfg_pkg::pa_t     lookup_addr,
  array_if.arb                 arr
);

  localparam int IDX_W   = $clog2(DC_SETS);
  localparam int TAG_LSB = lsu_cfg_pkg::DW_OFFSET_W + IDX_W;
  localparam int PA_W    = lsu_cfg_pkg::PA_W;

  // fixed priority, refill first
  assign arb_grant = arb_req && !refill_vld;

  // walker lookup
  assign arr.rd_en  = arb_grant;
  assign arr.rd_idx = rd_addr[TAG_LSB-1:lsu_cfg_pkg::DW_OFFSET_W];

  // refill write, tag with low bits zeroed
  assign arr.wr_en   = refill_vld;
  assign arr.wr_idx  = refill_addr[TAG_LSB-1:lsu_cfg_pkg::DW_OFFSET_W];
  assign arr.wr_tag  = {refill_addr[PA_W-1:TAG_LSB], {TAG_LSB{1'b0}}};
  assign arr.wr_data = refill_data;

  // address of the read in flight
  // lines up with the registered array output
  always_ff @(posedge ptw_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      lookup_addr <= '0;
    else if (arb_grant)
      lookup_addr <= rd_addr;
  end

endmodule

// File: verilog/lsu_dcache_array.sv
`timescale 1ns/100ps

module lsu_dcache_array #(
  parameter int DC_SETS = 64
) (
  input  logic     ptw_clk,
  input  logic     cpurst_b,
  array_if.array   arr
);

  // one valid bit per line
  logic [DC_SETS-1:0]   line_vld;
  // tag and data storage
  lsu_cfg_pkg::dc_tag_t tag_mem  [DC_SETS];
  lsu_cfg_pkg::dword_t  data_mem [DC_SETS];

  // ======================================================================
  // valid bits
  // ======================================================================
  always_ff @(posedge ptw_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      line_vld   <= '0;
      arr.rd_vld <= 1'b0;
    end else begin
      if (arr.wr_en)
        line_vld[arr.wr_idx] <= 1'b1;
      // valid flag of the line read
      if (arr.rd_en)
        arr.rd_vld <= line_vld[arr.rd_idx];
    end
  end

  // ======================================================================
  // tag and data
  // ======================================================================
  always_ff @(posedge ptw_clk) begin
    if (arr.wr_en) begin
      tag_mem[arr.wr_idx]  <= arr.wr_tag;
      data_mem[arr.wr_idx] <= arr.wr_data;
    end
    // registered read, result one cycle after rd_en
    if (arr.rd_en) begin
      arr.rd_tag  <= tag_mem[arr.rd_idx];
      arr.rd_data <= data_mem[arr.rd_idx];
    end
  end

endmodule

// File: verilog/lsu_dcache_dc.sv
`timescale 1ns/100ps

module lsu_dcache_dc #(
  parameter int DC_SETS = 64
) (
  input  logic                    ptw_clk,
  input  logic                    cpurst_b,
  input  lsu_cfg_pkg::pa_t        lookup_addr,
  input  logic                    arready,
  input  logic                    rvalid,
  input  lsu_cfg_pkg::dword_t     rdata,
  input  lsu_ctrl_pkg::axi_resp_t rresp,
  output logic                    dc_busy,
  output logic                    refill_vld,
  output lsu_cfg_pkg::pa_t        refill_addr,
  output lsu_cfg_pkg::dword_t     refill_data,
  output logic                    arvalid,
  output lsu_cfg_pkg::pa_t        araddr,
  output logic [2:0]              arprot,
  output logic                    rready,
  dc_req_if.dc                    dc_req,
  array_if.dc                     arr
);

  localparam int IDX_W   = $clog2(DC_SETS);
  localparam int TAG_LSB = lsu_cfg_pkg::DW_OFFSET_W + IDX_W;
  localparam int PA_W    = lsu_cfg_pkg::PA_W;

  lsu_ctrl_pkg::dc_state_t dc_cur_state;
  lsu_ctrl_pkg::dc_state_t dc_next_state;
  // captured request
  lsu_cfg_pkg::pa_t        req_addr;
  lsu_cfg_pkg::byte_mask_t req_bytes_vld;
  lsu_ctrl_pkg::priv_t     req_priv;
  // captured bus response
  lsu_cfg_pkg::dword_t     bus_data;
  logic                    bus_err;
  // lookup
  lsu_cfg_pkg::dc_tag_t    lookup_tag;
  logic                    dc_hit;
  lsu_cfg_pkg::dword_t     resp_src;
  lsu_cfg_pkg::dword_t     lane_mask;

  // ======================================================================
  // dcache stage fsm
  // ======================================================================
  always_ff @(posedge ptw_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      dc_cur_state <= lsu_ctrl_pkg::DC_IDLE;
    else
      dc_cur_state <= dc_next_state;
  end

  always_comb begin
    dc_next_state = dc_cur_state;
    case (dc_cur_state)
      lsu_ctrl_pkg::DC_IDLE:
        if (dc_req.req)
          dc_next_state = lsu_ctrl_pkg::DC_LOOKUP;
      // hit answers here, miss goes to the bus
      lsu_ctrl_pkg::DC_LOOKUP:
        dc_next_state = dc_hit ? lsu_ctrl_pkg::DC_IDLE : lsu_ctrl_pkg::DC_BUS_ADDR;
      lsu_ctrl_pkg::DC_BUS_ADDR:
        if (arready)
          dc_next_state = lsu_ctrl_pkg::DC_BUS_DATA;
      lsu_ctrl_pkg::DC_BUS_DATA:
        if (rvalid)
          dc_next_state = lsu_ctrl_pkg::DC_RESPOND;
      lsu_ctrl_pkg::DC_RESPOND:
        dc_next_state = lsu_ctrl_pkg::DC_IDLE;
      default: dc_next_state = lsu_ctrl_pkg::DC_IDLE;
    endcase
  end

  assign dc_busy = (dc_cur_state != lsu_ctrl_pkg::DC_IDLE);

  // request fields, only taken when idle
  always_ff @(posedge ptw_clk) begin
    if (dc_req.req && (dc_cur_state == lsu_ctrl_pkg::DC_IDLE)) begin
      req_addr      <= dc_req.addr;
      req_bytes_vld <= dc_req.bytes_vld;
      req_priv      <= dc_req.priv_mode;
    end
    // r handshake
    if (rready && rvalid) begin
      bus_data <= rdata;
      bus_err  <= (rresp != lsu_ctrl_pkg::AXI_OKAY);
    end
  end

  // ======================================================================
  // tag compare
  // ======================================================================
  assign lookup_tag = {lookup_addr[PA_W-1:TAG_LSB], {TAG_LSB{1'b0}}};
  assign dc_hit     = arr.rd_vld && (arr.rd_tag == lookup_tag);

  // ======================================================================
  // axi4-lite read
  // ======================================================================
  assign arvalid = (dc_cur_state == lsu_ctrl_pkg::DC_BUS_ADDR);
  // doubleword aligned
  assign araddr  = {req_addr[PA_W-1:lsu_cfg_pkg::DW_OFFSET_W],
                    {lsu_cfg_pkg::DW_OFFSET_W{1'b0}}};
  // bit 0 privileged, data, secure
  assign arprot  = {2'b00, (req_priv != lsu_ctrl_pkg::PRIV_U)};
  assign rready  = (dc_cur_state == lsu_ctrl_pkg::DC_BUS_DATA);

  // ======================================================================
  // response and refill
  // ======================================================================
  // expand byte lanes to bit mask
  always_comb begin
    for (int i = 0; i < lsu_cfg_pkg::DW_BYTES; i++) begin
      lane_mask[i*8 +: 8] = {8{req_bytes_vld[i]}};
    end
  end

  assign resp_src = (dc_cur_state == lsu_ctrl_pkg::DC_RESPOND) ? bus_data : arr.rd_data;

  assign dc_req.resp_vld  = ((dc_cur_state == lsu_ctrl_pkg::DC_LOOKUP) && dc_hit) ||
                            ((dc_cur_state == lsu_ctrl_pkg::DC_RESPOND) && !bus_err);
  assign dc_req.resp_err  = (dc_cur_state == lsu_ctrl_pkg::DC_RESPOND) && bus_err;
  assign dc_req.resp_data = resp_src & lane_mask;

  // whole line back into the array, okay only
  assign refill_vld  = (dc_cur_state == lsu_ctrl_pkg::DC_RESPOND) && !bus_err;
  assign refill_addr = req_addr;
  assign refill_data = bus_data;

endmodule

// File: verilog/lsu_ptw_top.sv
`timescale 1ns/100ps

module lsu_ptw_top #(
  parameter int DC_SETS = 64
) (
  input  logic                    ptw_clk,
  input  logic                    cpurst_b,
  // mmu
  input  logic                    mmu_req,
  input  lsu_cfg_pkg::pa_t        mmu_addr,
  input  logic                    mmu_size,
  output logic                    mmu_data_vld,
  output logic                    mmu_bus_err,
  output lsu_cfg_pkg::dword_t     mmu_data,
  // cp0 and icache
  input  logic                    mprv,
  input  lsu_ctrl_pkg::priv_t     mpp,
  input  lsu_ctrl_pkg::priv_t     priv_mode,
  input  logic                    icc_idle,
  // axi4-lite read
  output logic                    arvalid,
  input  logic                    arready,
  output lsu_cfg_pkg::pa_t        araddr,
  output logic [2:0]              arprot,
  input  logic                    rvalid,
  output logic                    rready,
  input  lsu_cfg_pkg::dword_t     rdata,
  input  lsu_ctrl_pkg::axi_resp_t rresp
);

  // walker to arbiter
  logic                arb_req;
  lsu_cfg_pkg::pa_t    rd_addr;
  logic                arb_grant;
  // dcache stage to arbiter and walker
  logic                dc_busy;
  logic                refill_vld;
  lsu_cfg_pkg::pa_t    refill_addr;
  lsu_cfg_pkg::dword_t refill_data;
  lsu_cfg_pkg::pa_t    lookup_addr;

  dc_req_if dc_req_bus ();
  array_if #(.DC_SETS(DC_SETS)) array_bus ();

  lsu_mcic u_mcic (
    .ptw_clk      (ptw_clk),
    .cpurst_b     (cpurst_b),
    .mmu_req      (mmu_req),
    .mmu_addr     (mmu_addr),
    .mmu_size     (mmu_size),
    .mprv         (mprv),
    .mpp          (mpp),
    .priv_mode    (priv_mode),
    .icc_idle     (icc_idle),
    .dc_busy      (dc_busy),
    .arb_grant    (arb_grant),
    .arb_req      (arb_req),
    .rd_addr      (rd_addr),
    .mmu_data_vld (mmu_data_vld),
    .mmu_bus_err  (mmu_bus_err),
    .mmu_data     (mmu_data),
    .dc_req       (dc_req_bus.mcic)
  );

  lsu_dcache_arb #(.DC_SETS(DC_SETS)) u_arb (
    .ptw_clk     (ptw_clk),
    .cpurst_b    (cpurst_b),
    .arb_req     (arb_req),
    .rd_addr     (rd_addr),
    .refill_vld  (refill_vld),
    .refill_addr (refill_addr),
    .refill_data (refill_data),
    .arb_grant   (arb_grant),
    .lookup_addr (lookup_addr),
    .arr         (array_bus.arb)
  );

  lsu_dcache_array #(.DC_SETS(DC_SETS)) u_array (
    .ptw_clk  (ptw_clk),
    .cpurst_b (cpurst_b),
    .arr      (array_bus.array)
  );

  lsu_dcache_dc #(.DC_SETS(DC_SETS)) u_dc (
    .ptw_clk     (ptw_clk),
    .cpurst_b    (cpurst_b),
    .lookup_addr (lookup_addr),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .dc_busy     (dc_busy),
    .refill_vld  (refill_vld),
    .refill_addr (refill_addr),
    .refill_data (refill_data),
    .arvalid     (arvalid),
    .araddr      (araddr),
    .arprot      (arprot),
    .rready      (rready),
    .dc_req      (dc_req_bus.dc),
    .arr         (array_bus.dc)
  );

endmodule

// File: bench/tb_lsu_ptw.sv
`timescale 1ns/100ps

module tb_lsu_ptw;

  localparam int WAIT_LIMIT = 200;

  logic                    ptw_clk;
  logic                    cpurst_b;
  logic                    mmu_req;
  lsu_cfg_pkg::pa_t        mmu_addr;
  logic                    mmu_size;
  logic                    mmu_data_vld;
  logic                    mmu_bus_err;
  lsu_cfg_pkg::dword_t     mmu_data;
  logic                    mprv;
  lsu_ctrl_pkg::priv_t     mpp;
  lsu_ctrl_pkg::priv_t     priv_mode;
  logic                    icc_idle;
  logic                    arvalid;
  logic                    arready;
  lsu_cfg_pkg::pa_t        araddr;
  logic [2:0]              arprot;
  logic                    rvalid;
  logic                    rready;
  lsu_cfg_pkg::dword_t     rdata;
  lsu_ctrl_pkg::axi_resp_t rresp;

  // responder bookkeeping
  int                      ar_count;
  lsu_cfg_pkg::pa_t        ar_addr_seen;
  logic [2:0]              ar_prot_seen;
  // last walker response
  lsu_cfg_pkg::dword_t     got_data;
  logic                    got_err;
  int                      got_lat;

  lsu_ptw_top dut0 (.*);

  initial begin
    ptw_clk = 1'b0;
    forever #20 ptw_clk = ~ptw_clk;
  end

  // ======================================================================
  // reference model and checking
  // ======================================================================
  // memory image derived from the doubleword number
  function automatic lsu_cfg_pkg::dword_t mem_word(input lsu_cfg_pkg::pa_t addr);
    logic [31:0] dw_num;
    dw_num = addr[34:3];
    return {~dw_num, dw_num};
  endfunction

  // lanes outside the access read as zero
  function automatic lsu_cfg_pkg::dword_t expect_data(input lsu_cfg_pkg::pa_t addr,
                                                      input logic size);
    lsu_cfg_pkg::dword_t keep;
    if (size)
      keep = (addr[2:0] == 3'b000) ? {64{1'b1}} : {64{1'b0}};
    else if (addr[2])
      keep = {32'hffff_ffff, 32'h0000_0000};
    else
      keep = {32'h0000_0000, 32'hffff_ffff};
    return mem_word(addr) & keep;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  // ======================================================================
  // axi4-lite read slave
  // ======================================================================
  initial begin
    int               seed_init;
    int               dly;
    lsu_cfg_pkg::pa_t addr;
    seed_init = $urandom(32'ha579d921);
    arready  <= 1'b0;
    rvalid   <= 1'b0;
    rdata    <= '0;
    rresp    <= lsu_ctrl_pkg::AXI_OKAY;
    ar_count = 0;
    forever begin
      @(negedge ptw_clk);
      if (arvalid === 1'b1) begin
        // address phase after 0 to 3 idle cycles
        dly = $urandom % 4;
        repeat (dly) @(posedge ptw_clk);
        @(posedge ptw_clk);
        arready <= 1'b1;
        @(negedge ptw_clk);
        check_eq("arvalid", 64'(arvalid), 64'd1);
        addr         = araddr;
        ar_addr_seen = araddr;
        ar_prot_seen = arprot;
        @(posedge ptw_clk);
        arready  <= 1'b0;
        ar_count = ar_count + 1;
        // data phase
        dly = $urandom % 4;
        repeat (dly) @(posedge ptw_clk);
        rvalid <= 1'b1;
        rdata  <= mem_word(addr);
        // top address bit marks a faulting region
        rresp  <= addr[lsu_cfg_pkg::PA_W-1] ? lsu_ctrl_pkg::AXI_SLVERR : lsu_ctrl_pkg::AXI_OKAY;
        @(negedge ptw_clk);
        check_eq("rready", 64'(rready), 64'd1);
        @(posedge ptw_clk);
        rvalid <= 1'b0;
      end
    end
  end

  // ======================================================================
  // mmu side
  // ======================================================================
  task automatic issue_req(input lsu_cfg_pkg::pa_t addr, input logic size);
    @(posedge ptw_clk);
    mmu_req  <= 1'b1;
    mmu_addr <= addr;
    mmu_size <= size;
  endtask

  // latency counted in cycles from the request edge
  task automatic wait_resp();
    got_lat = 0;
    do begin
      @(negedge ptw_clk);
      got_lat = got_lat + 1;
    end while (!mmu_data_vld && !mmu_bus_err && got_lat < WAIT_LIMIT);
    if (!mmu_data_vld && !mmu_bus_err)
      abort_run("Timeout: the walker request got no response");
    else begin
      got_data = mmu_data;
      got_err  = mmu_bus_err;
      // data valid and bus error never together
      check_eq("mmu_data_vld", 64'(mmu_data_vld), 64'(!mmu_bus_err));
      @(posedge ptw_clk);
      mmu_req <= 1'b0;
    end
  endtask

  task automatic read_check(input lsu_cfg_pkg::pa_t addr, input logic size, input int new_ars);
    int ar_before;
    ar_before = ar_count;
    issue_req(addr, size);
    wait_resp();
    check_eq("mmu_bus_err", 64'(got_err), 64'd0);
    check_eq("mmu_data", got_data, expect_data(addr, size));
    check_eq("ar_count", 64'(ar_count - ar_before), 64'(new_ars));
    if (new_ars > 0)
      check_eq("araddr", 64'(ar_addr_seen), 64'({addr[39:3], 3'b000}));
  endtask

  // ======================================================================
  // directed tests
  // ======================================================================
  task automatic reset_outputs_idle();
    @(negedge ptw_clk);
    check_eq("mmu_data_vld", 64'(mmu_data_vld), 64'd0);
    check_eq("mmu_bus_err", 64'(mmu_bus_err), 64'd0);
    check_eq("arvalid", 64'(arvalid), 64'd0);
    check_eq("rready", 64'(rready), 64'd0);
  endtask

  task automatic miss_privilege_prot();
    lsu_ctrl_pkg::priv_t modes [3];
    modes[0] = lsu_ctrl_pkg::PRIV_U;
    modes[1] = lsu_ctrl_pkg::PRIV_S;
    modes[2] = lsu_ctrl_pkg::PRIV_M;
    for (int i = 0; i < 3; i++) begin
      @(posedge ptw_clk);
      priv_mode <= modes[i];
      // one fresh line per mode
      read_check(40'h00_1000_0100 + 40'(i * 8), 1'b1, 1);
      check_eq("arprot[0]", 64'(ar_prot_seen[0]), 64'(modes[i] != lsu_ctrl_pkg::PRIV_U));
    end
  endtask

  task automatic hit_and_replace();
    read_check(40'h00_2000_0040, 1'b1, 1);
    read_check(40'h00_2000_0040, 1'b1, 0);
    check_eq("hit latency", 64'(got_lat), 64'd2);
    // same index, other tag
    read_check(40'h00_3000_0040, 1'b1, 1);
    read_check(40'h00_2000_0040, 1'b1, 1);
  endtask

  task automatic word_lane_select();
    read_check(40'h00_4000_00c4, 1'b0, 1);
    read_check(40'h00_4000_00c0, 1'b0, 0);
    read_check(40'h00_4000_00c4, 1'b0, 0);
    // low lanes on a miss
    read_check(40'h00_5000_0180, 1'b0, 1);
  endtask

  task automatic bus_error_retry();
    int ar_before;
    for (int i = 0; i < 2; i++) begin
      ar_before = ar_count;
      issue_req(40'h80_0000_0200, 1'b1);
      wait_resp();
      check_eq("mmu_bus_err", 64'(got_err), 64'd1);
      // no refill, so the repeat goes to the bus
      check_eq("ar_count", 64'(ar_count - ar_before), 64'd1);
    end
  endtask

  task automatic mprv_user_prot();
    @(posedge ptw_clk);
    mprv      <= 1'b1;
    mpp       <= lsu_ctrl_pkg::PRIV_U;
    priv_mode <= lsu_ctrl_pkg::PRIV_M;
    read_check(40'h00_6000_0208, 1'b1, 1);
    check_eq("arprot[0]", 64'(ar_prot_seen[0]), 64'd0);
    @(posedge ptw_clk);
    priv_mode <= lsu_ctrl_pkg::PRIV_S;
    read_check(40'h00_6000_0210, 1'b1, 1);
    check_eq("arprot[0]", 64'(ar_prot_seen[0]), 64'd0);
    // mpp machine with current mode user
    @(posedge ptw_clk);
    mpp       <= lsu_ctrl_pkg::PRIV_M;
    priv_mode <= lsu_ctrl_pkg::PRIV_U;
    read_check(40'h00_6000_0218, 1'b1, 1);
    check_eq("arprot[0]", 64'(ar_prot_seen[0]), 64'd1);
    @(posedge ptw_clk);
    mprv <= 1'b0;
  endtask

  task automatic icc_idle_hold();
    int ar_before;
    @(posedge ptw_clk);
    icc_idle <= 1'b0;
    ar_before = ar_count;
    issue_req(40'h00_7000_0300, 1'b1);
    for (int i = 0; i < 20; i++) begin
      @(negedge ptw_clk);
      check_eq("arvalid", 64'(arvalid), 64'd0);
      check_eq("mmu_data_vld", 64'(mmu_data_vld), 64'd0);
    end
    @(posedge ptw_clk);
    icc_idle <= 1'b1;
    wait_resp();
    check_eq("mmu_bus_err", 64'(got_err), 64'd0);
    check_eq("mmu_data", got_data, expect_data(40'h00_7000_0300, 1'b1));
    check_eq("ar_count", 64'(ar_count - ar_before), 64'd1);
  endtask

  // ======================================================================
  // sequence
  // ======================================================================
  initial begin
    cpurst_b  <= 1'b0;
    mmu_req   <= 1'b0;
    mmu_addr  <= '0;
    mmu_size  <= 1'b0;
    mprv      <= 1'b0;
    mpp       <= lsu_ctrl_pkg::PRIV_M;
    priv_mode <= lsu_ctrl_pkg::PRIV_M;
    icc_idle  <= 1'b1;
    repeat (8) @(posedge ptw_clk);
    cpurst_b <= 1'b1;
    reset_outputs_idle();
    miss_privilege_prot();
    hit_and_replace();
    word_lane_select();
    bus_error_retry();
    mprv_user_prot();
    icc_idle_hold();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: src.f
verilog/lsu_cfg_pkg.sv
verilog/lsu_ctrl_pkg.sv
verilog/dc_req_if.sv
verilog/lsu_mcic.sv
verilog/lsu_dcache_arb.sv
verilog/lsu_dcache_array.sv
verilog/lsu_dcache_dc.sv
verilog/lsu_ptw_top.sv
bench/tb_lsu_ptw.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the walker path testbench with verilator
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -j 0 -f src.f --top-module tb_lsu_ptw \
  --Mdir "$build_dir" -o tb_lsu_ptw
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$build_dir/tb_lsu_ptw" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "FAIL: see errors above" "$log_file"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
echo "simulation finished without failure"
exit 0
